// ==== src/tx_macproc_pkg.sv ====
`default_nettype none

package tx_macproc_pkg;

  localparam int DATA_WIDTH = 64;
  localparam int KEEP_WIDTH = 8;
  localparam int LEN_WIDTH = 13;
  localparam int ADDR_WIDTH = 32;
  localparam int HEAD_WIDTH = 64;
  localparam int BEAT_SHIFT = $clog2(KEEP_WIDTH);

  // dma header: address in the upper half, byte length at the bottom
  localparam int HEAD_ADDR_LSB = 32;

  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [KEEP_WIDTH-1:0] keep_t;
  typedef logic [LEN_WIDTH-1:0] len_t;
  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [7:0] qnum_t;
  typedef logic [15:0] qindex_t;
  typedef logic [HEAD_WIDTH-1:0] head_t;

  localparam len_t CPL_BYTES = len_t'(8);

  function automatic head_t make_head(input addr_t addr, input len_t len);
    head_t head;
    head = '0;
    head[HEAD_ADDR_LSB +: ADDR_WIDTH] = addr;
    head[LEN_WIDTH-1:0] = len;
    return head;
  endfunction

  // beats needed for len bytes, rounded up
  function automatic len_t beat_count(input len_t len);
    return (len >> BEAT_SHIFT) + len_t'(|len[BEAT_SHIFT-1:0]);
  endfunction

endpackage

`default_nettype wire

// ==== src/tx_desc_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module tx_desc_table
  import tx_macproc_pkg::*;
#(
  parameter int DESC_TABLE_SIZE = 16
) (
  input  wire logic    clk,
  input  wire logic    rst_n,
  input  wire logic    desc_valid,
  input  wire qnum_t   desc_qnum,
  input  wire qindex_t desc_qindex,
  input  wire len_t    desc_len,
  input  wire addr_t   desc_dma_addr,
  input  wire addr_t   desc_cpl_addr,
  input  wire logic    req_done,
  input  wire logic    rsp_done,
  input  wire logic    trans_done,
  input  wire logic    cpl_done,
  input  wire logic    fin_done,
  output logic         desc_ready,
  output logic         req_pending,
  output addr_t        req_addr,
  output len_t         req_len,
  output len_t         trans_len,
  output len_t         cpl_len,
  output logic         cpl_pending,
  output qnum_t        cpl_qnum,
  output qnum_t        fin_qnum,
  output qindex_t      cpl_qindex,
  output addr_t        cpl_addr,
  output logic         fin_pending
);

  localparam int IDX_W = $clog2(DESC_TABLE_SIZE);
  localparam int PTR_W = IDX_W + 1;

  typedef logic [PTR_W-1:0] ptr_t;
  typedef logic [IDX_W-1:0] idx_t;

  // extra msb tells a full table from an empty one
  ptr_t start_ptr, req_ptr, trans_ptr, cpl_ptr, fin_ptr;
  ptr_t live_cnt;
  idx_t start_idx, req_idx, trans_idx, cpl_idx, fin_idx;
  logic start_en;

  qnum_t   qnum_mem     [DESC_TABLE_SIZE];
  qindex_t qindex_mem   [DESC_TABLE_SIZE];
  len_t    len_mem      [DESC_TABLE_SIZE];
  addr_t   dma_addr_mem [DESC_TABLE_SIZE];
  addr_t   cpl_addr_mem [DESC_TABLE_SIZE];

  assign start_idx = start_ptr[IDX_W-1:0];
  assign req_idx   = req_ptr[IDX_W-1:0];
  assign trans_idx = trans_ptr[IDX_W-1:0];
  assign cpl_idx   = cpl_ptr[IDX_W-1:0];
  assign fin_idx   = fin_ptr[IDX_W-1:0];

  // entries stay live until the queue manager takes the finish
  assign live_cnt   = start_ptr - fin_ptr;
  assign desc_ready = live_cnt < ptr_t'(DESC_TABLE_SIZE);
  assign start_en   = desc_valid && desc_ready;

  always_ff @(posedge clk) begin
    if (start_en) begin
      qnum_mem[start_idx]     <= desc_qnum;
      qindex_mem[start_idx]   <= desc_qindex;
      len_mem[start_idx]      <= desc_len;
      dma_addr_mem[start_idx] <= desc_dma_addr;
      cpl_addr_mem[start_idx] <= desc_cpl_addr;
    end
  end

  // ****************************************
  // stage pointers
  // ****************************************
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      start_ptr <= '0;
      req_ptr   <= '0;
      trans_ptr <= '0;
      cpl_ptr   <= '0;
      fin_ptr   <= '0;
    end else begin
      if (start_en) begin
        start_ptr <= start_ptr + 1'b1;
      end
      if (req_done) begin
        req_ptr <= req_ptr + 1'b1;
      end
      if (trans_done) begin
        trans_ptr <= trans_ptr + 1'b1;
      end
      if (cpl_done) begin
        cpl_ptr <= cpl_ptr + 1'b1;
      end
      if (fin_done) begin
        fin_ptr <= fin_ptr + 1'b1;
      end
    end
  end

  assign req_pending = req_ptr != start_ptr;
  // record goes out once the frame has left for the mac
  assign cpl_pending = cpl_ptr != trans_ptr;
  assign fin_pending = fin_ptr != cpl_ptr;

  // entry fields at each stage pointer
  assign req_addr   = dma_addr_mem[req_idx];
  assign req_len    = len_mem[req_idx];
  assign trans_len  = len_mem[trans_idx];
  assign cpl_len    = len_mem[cpl_idx];
  assign cpl_qnum   = qnum_mem[cpl_idx];
  assign cpl_qindex = qindex_mem[cpl_idx];
  assign cpl_addr   = cpl_addr_mem[cpl_idx];
  assign fin_qnum   = qnum_mem[fin_idx];

endmodule

`default_nettype wire

// ==== src/tx_frame_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module tx_frame_fetch
  import tx_macproc_pkg::*;
#(
  parameter int PKT_FIFO_DEPTH = 32
) (
  input  wire logic                            req_pending,
  input  wire addr_t                           req_addr,
  input  wire len_t                            req_len,
  input  wire logic [$clog2(PKT_FIFO_DEPTH):0] fifo_free,
  input  wire logic                            frame_req_ready,
  output logic                                 frame_req_valid,
  output logic                                 frame_req_last,
  output head_t                                frame_req_head,
  output logic                                 req_done,
  output len_t                                 req_beats
);

  logic room_ok;

  // whole frame must fit in the packet buffer before the read goes out
  assign req_beats = beat_count(req_len);
  assign room_ok   = req_beats <= len_t'(fifo_free);

  assign frame_req_valid = req_pending && room_ok;
  // single beat request
  assign frame_req_last  = frame_req_valid;
  assign frame_req_head  = make_head(req_addr, req_len);

  assign req_done = frame_req_valid && frame_req_ready;

endmodule

`default_nettype wire

// ==== src/tx_pkt_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module tx_pkt_fifo
  import tx_macproc_pkg::*;
#(
  parameter int PKT_FIFO_DEPTH = 32
) (
  input  wire logic                        clk,
  input  wire logic                        rst_n,
  input  wire logic                        rsp_valid,
  input  wire logic                        rsp_last,
  input  wire data_t                       rsp_data,
  input  wire logic                        rd_en,
  input  wire logic                        req_done,
  input  wire len_t                        req_beats,
  output logic                             rsp_ready,
  output logic                             rsp_done,
  output logic                             out_valid,
  output logic                             out_last,
  output data_t                            out_data,
  output logic [$clog2(PKT_FIFO_DEPTH):0]  fifo_free
);

  localparam int AW = $clog2(PKT_FIFO_DEPTH);

  typedef logic [AW:0] cnt_t;

  data_t         data_mem [PKT_FIFO_DEPTH];
  logic          last_mem [PKT_FIFO_DEPTH];
  logic [AW-1:0] wr_ptr, rd_ptr;
  cnt_t          count;
  cnt_t          reserved;
  cnt_t          res_add;
  logic          wr_en;

  assign rsp_ready = count != cnt_t'(PKT_FIFO_DEPTH);
  assign wr_en     = rsp_valid && rsp_ready;
  assign rsp_done  = wr_en && rsp_last;

  // show-ahead read side
  assign out_valid = count != '0;
  assign out_data  = data_mem[rd_ptr];
  assign out_last  = last_mem[rd_ptr];

  // beats already requested but not yet written are not free
  assign res_add   = req_done ? cnt_t'(req_beats) : '0;
  assign fifo_free = cnt_t'(PKT_FIFO_DEPTH) - count - reserved;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      data_mem[wr_ptr] <= rsp_data;
      last_mem[wr_ptr] <= rsp_last;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      reserved <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count    <= count + cnt_t'(wr_en) - cnt_t'(rd_en);
      // each written beat releases one reserved slot
      reserved <= reserved + res_add - cnt_t'(wr_en);
    end
  end

endmodule

`default_nettype wire

// ==== src/tx_mac_send.sv ====
`timescale 1ns/1ps
`default_nettype none

module tx_mac_send
  import tx_macproc_pkg::*;
(
  input  wire logic  out_valid,
  input  wire logic  out_last,
  input  wire data_t out_data,
  input  wire len_t  trans_len,
  input  wire logic  axis_ready,
  output logic       rd_en,
  output logic       axis_valid,
  output logic       axis_last,
  output data_t      axis_data,
  output keep_t      axis_data_be,
  output logic       trans_done
);

  logic [BEAT_SHIFT-1:0] tail_bytes;
  keep_t                 last_be;

  // bytes used in the final beat, zero means a full beat
  assign tail_bytes = trans_len[BEAT_SHIFT-1:0];

  always_comb begin
    if (tail_bytes == '0) begin
      last_be = '1;
    end else begin
      last_be = ~(keep_t'('1) << tail_bytes);
    end
  end

  assign axis_valid   = out_valid;
  assign axis_last    = out_valid && out_last;
  assign axis_data    = out_data;
  assign axis_data_be = axis_last ? last_be : '1;

  // pop on handshake
  assign rd_en      = axis_valid && axis_ready;
  assign trans_done = rd_en && axis_last;

endmodule

`default_nettype wire

// ==== src/tx_cpl_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

module tx_cpl_writer
  import tx_macproc_pkg::*;
(
  input  wire logic    cpl_pending,
  input  wire len_t    cpl_len,
  input  wire qnum_t   cpl_qnum,
  input  wire qindex_t cpl_qindex,
  input  wire addr_t   cpl_addr,
  input  wire logic    cpl_wr_ready,
  input  wire logic    fin_pending,
  input  wire qnum_t   fin_qnum,
  input  wire logic    finish_ready,
  output logic         cpl_wr_valid,
  output logic         cpl_wr_last,
  output data_t        cpl_wr_data,
  output head_t        cpl_wr_head,
  output logic         cpl_done,
  output logic         finish_valid,
  output qnum_t        finish_qnum,
  output logic         fin_done
);

  data_t record;

  // ****************************************
  // completion record
  // ****************************************

  // frame_len 47:32, qindex 31:16, qnum 15:0
  always_comb begin
    record        = '0;
    record[47:32] = 16'(cpl_len);
    record[31:16] = cpl_qindex;
    record[15:0]  = 16'(cpl_qnum);
  end

  assign cpl_wr_valid = cpl_pending;
  // one beat per record
  assign cpl_wr_last  = cpl_wr_valid;
  assign cpl_wr_data  = record;
  assign cpl_wr_head  = make_head(cpl_addr, CPL_BYTES);
  assign cpl_done     = cpl_wr_valid && cpl_wr_ready;

  // ****************************************
  // queue finish
  // ****************************************
  assign finish_valid = fin_pending;
  assign finish_qnum  = fin_qnum;
  assign fin_done     = finish_valid && finish_ready;

endmodule

`default_nettype wire

// ==== src/tx_macproc.sv ====
`timescale 1ns/1ps
`default_nettype none

module tx_macproc
  import tx_macproc_pkg::*;
#(
  parameter int DESC_TABLE_SIZE = 16,
  parameter int PKT_FIFO_DEPTH  = 32
) (
  input  wire logic    clk,
  input  wire logic    rst_n,
  // descriptor input
  input  wire logic    tx_desc_valid,
  input  wire qnum_t   tx_desc_qnum,
  input  wire qindex_t tx_desc_qindex,
  input  wire len_t    tx_desc_frame_len,
  input  wire addr_t   tx_desc_dma_addr,
  input  wire addr_t   tx_desc_cpl_addr,
  output logic         tx_desc_ready,
  // dma read request
  output logic         tx_frame_req_valid,
  output logic         tx_frame_req_last,
  output head_t        tx_frame_req_head,
  input  wire logic    tx_frame_req_ready,
  // dma read response
  input  wire logic    tx_frame_rsp_valid,
  input  wire logic    tx_frame_rsp_last,
  input  wire data_t   tx_frame_rsp_data,
  output logic         tx_frame_rsp_ready,
  // mac stream
  output logic         axis_tx_valid,
  output logic         axis_tx_last,
  output data_t        axis_tx_data,
  output keep_t        axis_tx_data_be,
  input  wire logic    axis_tx_ready,
  // completion write
  output logic         tx_cpl_wr_valid,
  output logic         tx_cpl_wr_last,
  output data_t        tx_cpl_wr_data,
  output head_t        tx_cpl_wr_head,
  input  wire logic    tx_cpl_wr_ready,
  // queue finish
  output logic         tx_cpl_finish_valid,
  output qnum_t        tx_cpl_finish_qnum,
  input  wire logic    tx_cpl_finish_ready
);

  logic    req_pending, cpl_pending, fin_pending;
  logic    req_done, rsp_done, trans_done, cpl_done, fin_done;
  addr_t   req_addr, cpl_addr;
  len_t    req_len, trans_len, cpl_len, req_beats;
  qnum_t   cpl_qnum, fin_qnum;
  qindex_t cpl_qindex;
  logic    [$clog2(PKT_FIFO_DEPTH):0] fifo_free;
  logic    fifo_rd, fifo_valid, fifo_last;
  data_t   fifo_data;

  // ****************************************
  // shared descriptor table
  // ****************************************
  tx_desc_table #(
    .DESC_TABLE_SIZE(DESC_TABLE_SIZE)
  ) i_desc_table (
    .clk          (clk),
    .rst_n        (rst_n),
    .desc_valid   (tx_desc_valid),
    .desc_qnum    (tx_desc_qnum),
    .desc_qindex  (tx_desc_qindex),
    .desc_len     (tx_desc_frame_len),
    .desc_dma_addr(tx_desc_dma_addr),
    .desc_cpl_addr(tx_desc_cpl_addr),
    .req_done     (req_done),
    .rsp_done     (rsp_done),
    .trans_done   (trans_done),
    .cpl_done     (cpl_done),
    .fin_done     (fin_done),
    .desc_ready   (tx_desc_ready),
    .req_pending  (req_pending),
    .req_addr     (req_addr),
    .req_len      (req_len),
    .trans_len    (trans_len),
    .cpl_len      (cpl_len),
    .cpl_pending  (cpl_pending),
    .cpl_qnum     (cpl_qnum),
    .fin_qnum     (fin_qnum),
    .cpl_qindex   (cpl_qindex),
    .cpl_addr     (cpl_addr),
    .fin_pending  (fin_pending)
  );

  // ****************************************
  // frame path
  // ****************************************
  tx_frame_fetch #(
    .PKT_FIFO_DEPTH(PKT_FIFO_DEPTH)
  ) i_frame_fetch (
    .req_pending    (req_pending),
    .req_addr       (req_addr),
    .req_len        (req_len),
    .fifo_free      (fifo_free),
    .frame_req_ready(tx_frame_req_ready),
    .frame_req_valid(tx_frame_req_valid),
    .frame_req_last (tx_frame_req_last),
    .frame_req_head (tx_frame_req_head),
    .req_done       (req_done),
    .req_beats      (req_beats)
  );

  tx_pkt_fifo #(
    .PKT_FIFO_DEPTH(PKT_FIFO_DEPTH)
  ) i_pkt_fifo (
    .clk      (clk),
    .rst_n    (rst_n),
    .rsp_valid(tx_frame_rsp_valid),
    .rsp_last (tx_frame_rsp_last),
    .rsp_data (tx_frame_rsp_data),
    .rd_en    (fifo_rd),
    .req_done (req_done),
    .req_beats(req_beats),
    .rsp_ready(tx_frame_rsp_ready),
    .rsp_done (rsp_done),
    .out_valid(fifo_valid),
    .out_last (fifo_last),
    .out_data (fifo_data),
    .fifo_free(fifo_free)
  );

  tx_mac_send i_mac_send (
    .out_valid   (fifo_valid),
    .out_last    (fifo_last),
    .out_data    (fifo_data),
    .trans_len   (trans_len),
    .axis_ready  (axis_tx_ready),
    .rd_en       (fifo_rd),
    .axis_valid  (axis_tx_valid),
    .axis_last   (axis_tx_last),
    .axis_data   (axis_tx_data),
    .axis_data_be(axis_tx_data_be),
    .trans_done  (trans_done)
  );

  // completion and finish
  tx_cpl_writer i_cpl_writer (
    .cpl_pending (cpl_pending),
    .cpl_len     (cpl_len),
    .cpl_qnum    (cpl_qnum),
    .cpl_qindex  (cpl_qindex),
    .cpl_addr    (cpl_addr),
    .cpl_wr_ready(tx_cpl_wr_ready),
    .fin_pending (fin_pending),
    .fin_qnum    (fin_qnum),
    .finish_ready(tx_cpl_finish_ready),
    .cpl_wr_valid(tx_cpl_wr_valid),
    .cpl_wr_last (tx_cpl_wr_last),
    .cpl_wr_data (tx_cpl_wr_data),
    .cpl_wr_head (tx_cpl_wr_head),
    .cpl_done    (cpl_done),
    .finish_valid(tx_cpl_finish_valid),
    .finish_qnum (tx_cpl_finish_qnum),
    .fin_done    (fin_done)
  );

endmodule

`default_nettype wire

// ==== test/tb_tx_macproc.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_tx_macproc
  import tx_macproc_pkg::*;
;

  localparam int TABLE_SIZE = 4;
  localparam int FIFO_DEPTH = 32;
  localparam int NUM_FRAMES = 8;
  localparam int T_RESET    = NUM_FRAMES;
  localparam int T_BP       = NUM_FRAMES + 1;
  localparam int NUM_TESTS  = NUM_FRAMES + 2;

  // ****************************************
  // frame table, stimulus and expected values
  // ****************************************
  localparam qnum_t   QNUM_TAB [NUM_FRAMES] = '{8'h03, 8'h11, 8'h07, 8'h2a,
                                                8'h05, 8'h3c, 8'h0e, 8'h21};
  localparam qindex_t QIDX_TAB [NUM_FRAMES] = '{16'h0010, 16'h0021, 16'h0102, 16'h0033,
                                                16'h0a04, 16'h0055, 16'hff06, 16'h0077};
  // lengths hit every value of len mod 8
  localparam len_t    LEN_TAB  [NUM_FRAMES] = '{13'd1, 13'd130, 13'd43, 13'd60,
                                                13'd13, 13'd198, 13'd95, 13'd64};
  localparam addr_t   DMA_TAB  [NUM_FRAMES] = '{32'h1000_0000, 32'h1000_4000,
                                                32'h2000_0800, 32'h2000_1000,
                                                32'h3000_0100, 32'h3000_2000,
                                                32'h4000_0040, 32'h4000_3000};
  localparam addr_t   CPL_TAB  [NUM_FRAMES] = '{32'h8000_0000, 32'h8000_0040,
                                                32'h8000_0080, 32'h8000_00c0,
                                                32'h8000_0100, 32'h8000_0140,
                                                32'h8000_0180, 32'h8000_01c0};
  localparam int      BEATS_TAB [NUM_FRAMES] = '{1, 17, 6, 8, 2, 25, 12, 8};
  localparam keep_t   BE_TAB   [NUM_FRAMES] = '{8'h01, 8'h03, 8'h07, 8'h0f,
                                                8'h1f, 8'h3f, 8'h7f, 8'hff};

  logic    clk = 1'b0;
  logic    rst_n;
  logic    tx_desc_valid;
  qnum_t   tx_desc_qnum;
  qindex_t tx_desc_qindex;
  len_t    tx_desc_frame_len;
  addr_t   tx_desc_dma_addr;
  addr_t   tx_desc_cpl_addr;
  logic    tx_desc_ready;
  logic    tx_frame_req_valid;
  logic    tx_frame_req_last;
  head_t   tx_frame_req_head;
  logic    tx_frame_req_ready = 1'b1;
  logic    tx_frame_rsp_valid = 1'b0;
  logic    tx_frame_rsp_last = 1'b0;
  data_t   tx_frame_rsp_data = '0;
  logic    tx_frame_rsp_ready;
  logic    axis_tx_valid;
  logic    axis_tx_last;
  data_t   axis_tx_data;
  keep_t   axis_tx_data_be;
  logic    axis_tx_ready = 1'b0;
  logic    tx_cpl_wr_valid;
  logic    tx_cpl_wr_last;
  data_t   tx_cpl_wr_data;
  head_t   tx_cpl_wr_head;
  logic    tx_cpl_wr_ready = 1'b0;
  logic    tx_cpl_finish_valid;
  qnum_t   tx_cpl_finish_qnum;
  logic    tx_cpl_finish_ready = 1'b0;

  // scoreboard state, written only by the monitor
  int    desc_cnt = 0;
  int    req_cnt = 0;
  int    mac_frame = 0;
  int    mac_beat = 0;
  int    cpl_cnt = 0;
  int    fin_cnt = 0;
  int    err_cnt = 0;
  int    test_err [NUM_TESTS];
  logic  saw_full = 1'b0;
  logic  reset_checked = 1'b0;
  addr_t req_addr_q [$];
  len_t  req_len_q [$];
  int    cycle_cnt = 0;
  int    cycle_limit = 0;

  tx_macproc #(
    .DESC_TABLE_SIZE(TABLE_SIZE),
    .PKT_FIFO_DEPTH (FIFO_DEPTH)
  ) i_dut (
    .clk                (clk),
    .rst_n              (rst_n),
    .tx_desc_valid      (tx_desc_valid),
    .tx_desc_qnum       (tx_desc_qnum),
    .tx_desc_qindex     (tx_desc_qindex),
    .tx_desc_frame_len  (tx_desc_frame_len),
    .tx_desc_dma_addr   (tx_desc_dma_addr),
    .tx_desc_cpl_addr   (tx_desc_cpl_addr),
    .tx_desc_ready      (tx_desc_ready),
    .tx_frame_req_valid (tx_frame_req_valid),
    .tx_frame_req_last  (tx_frame_req_last),
    .tx_frame_req_head  (tx_frame_req_head),
    .tx_frame_req_ready (tx_frame_req_ready),
    .tx_frame_rsp_valid (tx_frame_rsp_valid),
    .tx_frame_rsp_last  (tx_frame_rsp_last),
    .tx_frame_rsp_data  (tx_frame_rsp_data),
    .tx_frame_rsp_ready (tx_frame_rsp_ready),
    .axis_tx_valid      (axis_tx_valid),
    .axis_tx_last       (axis_tx_last),
    .axis_tx_data       (axis_tx_data),
    .axis_tx_data_be    (axis_tx_data_be),
    .axis_tx_ready      (axis_tx_ready),
    .tx_cpl_wr_valid    (tx_cpl_wr_valid),
    .tx_cpl_wr_last     (tx_cpl_wr_last),
    .tx_cpl_wr_data     (tx_cpl_wr_data),
    .tx_cpl_wr_head     (tx_cpl_wr_head),
    .tx_cpl_wr_ready    (tx_cpl_wr_ready),
    .tx_cpl_finish_valid(tx_cpl_finish_valid),
    .tx_cpl_finish_qnum (tx_cpl_finish_qnum),
    .tx_cpl_finish_ready(tx_cpl_finish_ready)
  );

  always #5 clk = ~clk;

  function automatic string test_name(input int t);
    if (t == T_RESET) begin
      return "reset";
    end
    if (t == T_BP) begin
      return "backpressure";
    end
    return $sformatf("frame%0d", t);
  endfunction

  task automatic report_mismatch(input int t, input string what,
                                 input logic [63:0] exp, input logic [63:0] act);
    $display("ERR %s %s: expected %h, actual %h", test_name(t), what, exp, act);
    err_cnt++;
    test_err[t]++;
  endtask

  task automatic report_problem(input int t, input string msg);
    $display("%s: %s", test_name(t), msg);
    err_cnt++;
    test_err[t]++;
  endtask

  // ****************************************
  // handshake checks, sampled at negedge
  // ****************************************
  task automatic check_reset_state();
    if (tx_frame_req_valid !== 1'b0) begin
      report_mismatch(T_RESET, "frame request valid", 64'd0, 64'(tx_frame_req_valid));
    end
    if (tx_frame_rsp_ready !== 1'b1) begin
      report_mismatch(T_RESET, "response ready", 64'd1, 64'(tx_frame_rsp_ready));
    end
    if (axis_tx_valid !== 1'b0) begin
      report_mismatch(T_RESET, "mac valid", 64'd0, 64'(axis_tx_valid));
    end
    if (tx_cpl_wr_valid !== 1'b0) begin
      report_mismatch(T_RESET, "completion valid", 64'd0, 64'(tx_cpl_wr_valid));
    end
    if (tx_cpl_finish_valid !== 1'b0) begin
      report_mismatch(T_RESET, "finish valid", 64'd0, 64'(tx_cpl_finish_valid));
    end
    $display("reset: %s", test_err[T_RESET] == 0 ? "ok" : "failed");
  endtask

  task automatic check_desc();
    logic exp_ready;
    // ready only while fewer entries than the table holds are live
    exp_ready = (desc_cnt - fin_cnt) < TABLE_SIZE;
    if (tx_desc_ready !== exp_ready) begin
      report_mismatch(T_BP, "descriptor ready", 64'(exp_ready), 64'(tx_desc_ready));
    end
    if (!tx_desc_ready) begin
      saw_full = 1'b1;
    end
    if (tx_desc_valid && tx_desc_ready) begin
      desc_cnt++;
    end
  endtask

  task automatic check_req();
    head_t exp_head;
    int    f;
    if (tx_frame_req_valid && tx_frame_req_ready) begin
      f = req_cnt;
      if (f >= NUM_FRAMES) begin
        report_problem(NUM_FRAMES - 1, "frame request issued after the last descriptor");
      end else begin
        exp_head = {DMA_TAB[f], 19'd0, LEN_TAB[f]};
        if (tx_frame_req_head !== exp_head) begin
          report_mismatch(f, "request head", exp_head, tx_frame_req_head);
        end
        if (tx_frame_req_last !== 1'b1) begin
          report_mismatch(f, "request last", 64'd1, 64'(tx_frame_req_last));
        end
      end
      req_addr_q.push_back(tx_frame_req_head[63:32]);
      req_len_q.push_back(tx_frame_req_head[12:0]);
      req_cnt++;
    end
  endtask

  task automatic check_finish();
    int f;
    if (tx_cpl_finish_valid && tx_cpl_finish_ready) begin
      f = fin_cnt;
      if (f >= NUM_FRAMES) begin
        report_problem(NUM_FRAMES - 1, "queue finish after the last frame");
      end else begin
        if (cpl_cnt <= f) begin
          report_problem(f, "queue finish before its completion record");
        end
        if (tx_cpl_finish_qnum !== QNUM_TAB[f]) begin
          report_mismatch(f, "finish qnum", 64'(QNUM_TAB[f]), 64'(tx_cpl_finish_qnum));
        end
        $display("frame%0d qnum %02h len %0d: %s", f, QNUM_TAB[f], LEN_TAB[f],
                 test_err[f] == 0 ? "ok" : "failed");
      end
      fin_cnt++;
    end
  endtask

  task automatic check_cpl();
    data_t exp_data;
    head_t exp_head;
    int    f;
    if (tx_cpl_wr_valid && tx_cpl_wr_ready) begin
      f = cpl_cnt;
      if (f >= NUM_FRAMES) begin
        report_problem(NUM_FRAMES - 1, "completion record after the last frame");
      end else begin
        if (mac_frame <= f) begin
          report_problem(f, "completion record before the last MAC beat");
        end
        exp_data = {16'h0, 3'b0, LEN_TAB[f], QIDX_TAB[f], 8'h0, QNUM_TAB[f]};
        exp_head = {CPL_TAB[f], 32'd8};
        if (tx_cpl_wr_data !== exp_data) begin
          report_mismatch(f, "completion data", exp_data, tx_cpl_wr_data);
        end
        if (tx_cpl_wr_head !== exp_head) begin
          report_mismatch(f, "completion head", exp_head, tx_cpl_wr_head);
        end
        if (tx_cpl_wr_last !== 1'b1) begin
          report_mismatch(f, "completion last", 64'd1, 64'(tx_cpl_wr_last));
        end
      end
      cpl_cnt++;
    end
  endtask

  task automatic check_mac();
    data_t exp_data;
    keep_t exp_be;
    logic  exp_last;
    int    f;
    if (axis_tx_valid && axis_tx_ready) begin
      f = mac_frame;
      if (f >= NUM_FRAMES) begin
        report_problem(NUM_FRAMES - 1, "MAC beat after the last frame");
      end else begin
        exp_data = {DMA_TAB[f] + 32'(mac_beat), DMA_TAB[f] + 32'(mac_beat)};
        exp_last = (mac_beat == BEATS_TAB[f] - 1);
        exp_be   = exp_last ? BE_TAB[f] : 8'hff;
        if (axis_tx_data !== exp_data) begin
          report_mismatch(f, $sformatf("mac data beat %0d", mac_beat), exp_data, axis_tx_data);
        end
        if (axis_tx_last !== exp_last) begin
          report_mismatch(f, $sformatf("mac last beat %0d", mac_beat),
                          64'(exp_last), 64'(axis_tx_last));
        end
        if (axis_tx_data_be !== exp_be) begin
          report_mismatch(f, $sformatf("mac byte enables beat %0d", mac_beat),
                          64'(exp_be), 64'(axis_tx_data_be));
        end
      end
      mac_beat++;
      if (axis_tx_last) begin
        if (f < NUM_FRAMES && mac_beat != BEATS_TAB[f]) begin
          report_mismatch(f, "mac beat count", 64'(BEATS_TAB[f]), 64'(mac_beat));
        end
        mac_frame++;
        mac_beat = 0;
      end
    end
  endtask

  // fixed order keeps same-edge events consistent
  always @(negedge clk) begin
    if (rst_n) begin
      if (!reset_checked) begin
        check_reset_state();
        reset_checked = 1'b1;
      end
      check_desc();
      check_req();
      check_finish();
      check_cpl();
      check_mac();
    end
  end

  // random ready patterns for the mac and completion sides
  always @(posedge clk) begin
    if (rst_n) begin
      axis_tx_ready       <= ($urandom_range(0, 3) != 0);
      tx_cpl_wr_ready     <= ($urandom_range(0, 1) != 0);
      tx_cpl_finish_ready <= ($urandom_range(0, 3) != 0);
    end
  end

  // dma model, answers requests in order
  initial begin : dma_responder
    addr_t a;
    len_t  l;
    int    beats;
    int    k;
    int    rsp_idx;
    rsp_idx = 0;
    forever begin
      @(posedge clk);
      if (rsp_idx < req_addr_q.size()) begin
        a = req_addr_q[rsp_idx];
        l = req_len_q[rsp_idx];
        rsp_idx++;
        beats = (int'(l) + 7) / 8;
        repeat ($urandom_range(0, 3)) @(posedge clk);
        for (k = 0; k < beats; k++) begin
          tx_frame_rsp_valid <= 1'b1;
          tx_frame_rsp_last  <= (k == beats - 1);
          tx_frame_rsp_data  <= {a + 32'(k), a + 32'(k)};
          @(negedge clk);
          while (!tx_frame_rsp_ready) begin
            @(negedge clk);
          end
          @(posedge clk);
        end
        tx_frame_rsp_valid <= 1'b0;
        tx_frame_rsp_last  <= 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("timeout after %0d cycles, %0d of %0d frames finished",
               cycle_cnt, fin_cnt, NUM_FRAMES);
      $display("Simulation failed");
      $finish;
    end
  end

  // ****************************************
  // main sequence
  // ****************************************
  initial begin : main_seq
    int   i;
    int   failed;
    int   errors;
    logic bp_ok;
    void'($urandom(32'he229));
    for (i = 0; i < NUM_TESTS; i++) begin
      test_err[i] = 0;
    end
    rst_n             = 1'b0;
    tx_desc_valid     = 1'b0;
    tx_desc_qnum      = '0;
    tx_desc_qindex    = '0;
    tx_desc_frame_len = '0;
    tx_desc_dma_addr  = '0;
    tx_desc_cpl_addr  = '0;
    cycle_limit = 200;
    for (i = 0; i < NUM_FRAMES; i++) begin
      cycle_limit += 40 * BEATS_TAB[i];
    end
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    for (i = 0; i < NUM_FRAMES; i++) begin
      @(posedge clk);
      tx_desc_valid     <= 1'b1;
      tx_desc_qnum      <= QNUM_TAB[i];
      tx_desc_qindex    <= QIDX_TAB[i];
      tx_desc_frame_len <= LEN_TAB[i];
      tx_desc_dma_addr  <= DMA_TAB[i];
      tx_desc_cpl_addr  <= CPL_TAB[i];
      @(negedge clk);
      while (!tx_desc_ready) begin
        @(negedge clk);
      end
    end
    @(posedge clk);
    tx_desc_valid <= 1'b0;

    while (fin_cnt < NUM_FRAMES) begin
      @(posedge clk);
    end
    // idle time to catch stray finishes or beats
    repeat (20) @(posedge clk);

    if (!saw_full) begin
      $display("backpressure: tx_desc_ready never fell while the table was full");
    end
    bp_ok = saw_full && test_err[T_BP] == 0;
    $display("backpressure: %s", bp_ok ? "ok" : "failed");
    failed = bp_ok ? 0 : 1;
    for (i = 0; i < T_BP; i++) begin
      if (test_err[i] != 0) begin
        failed++;
      end
    end
    errors = err_cnt + (saw_full ? 0 : 1);
    $display("tests %0d, failed %0d, errors %0d", NUM_TESTS, failed, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
src/tx_macproc_pkg.sv
src/tx_desc_table.sv
src/tx_frame_fetch.sv
src/tx_pkt_fifo.sv
src/tx_mac_send.sv
src/tx_cpl_writer.sv
src/tx_macproc.sv
test/tb_tx_macproc.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f compile.f --top-module tb_tx_macproc -o sim_tb_tx_macproc
if [ $? -ne 0 ]; then
  echo "verilator build did not succeed"
  exit 1
fi

out=$(./obj_dir/sim_tb_tx_macproc)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Simulation passed"; then
  exit 0
fi
exit 1
